//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_soc_bus
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJDIR)

//--- hw/dbus_decode.sv
module dbus_decode (
    input  soc_bus_pkg::bus_req_t    req_i,

    output soc_bus_pkg::target_req_t ram_req_o,
    output soc_bus_pkg::target_req_t gpio_req_o,
    output soc_bus_pkg::target_req_t tmr_req_o,

    input  soc_bus_pkg::word_t       ram_rdata_i,
    input  soc_bus_pkg::word_t       gpio_rdata_i,
    input  soc_bus_pkg::word_t       tmr_rdata_i,
    input  logic                     ram_stall_i,

    output soc_bus_pkg::word_t       rddata_o,
    output logic                     stall_o
);

    soc_bus_pkg::addr_t ram_rel;
    soc_bus_pkg::addr_t gpio_rel;
    soc_bus_pkg::addr_t tmr_rel;
    logic               ram_hit;
    logic               gpio_hit;
    logic               tmr_hit;

    // build the request a target sees, strobes only when selected
    function automatic soc_bus_pkg::target_req_t route(
        input soc_bus_pkg::bus_req_t req,
        input soc_bus_pkg::addr_t    rel,
        input logic                  hit
    );
        soc_bus_pkg::target_req_t t;
        t.offset = rel[$bits(soc_bus_pkg::offset_t)-1:0];
        t.wrdata = req.wrdata;
        t.be     = req.be;
        t.read   = req.read & hit;
        t.write  = req.write & hit;
        return t;
    endfunction

    // offsets relative to each base, wraps high when below it
    assign ram_rel  = req_i.addr - soc_bus_pkg::RAM_BASE;
    assign gpio_rel = req_i.addr - soc_bus_pkg::GPIO_BASE;
    assign tmr_rel  = req_i.addr - soc_bus_pkg::TIMER_BASE;

    assign ram_hit  = ram_rel < soc_bus_pkg::RAM_WINDOW;
    assign gpio_hit = gpio_rel < soc_bus_pkg::PERIPH_WINDOW;
    assign tmr_hit  = tmr_rel < soc_bus_pkg::PERIPH_WINDOW;

    assign ram_req_o  = route(req_i, ram_rel, ram_hit);
    assign gpio_req_o = route(req_i, gpio_rel, gpio_hit);
    assign tmr_req_o  = route(req_i, tmr_rel, tmr_hit);

    always_comb begin
        rddata_o = '0;   // unmapped reads as zero
        stall_o  = 1'b0;
        if (ram_hit) begin
            rddata_o = ram_rdata_i;
            stall_o  = ram_stall_i;
        end else if (gpio_hit) begin
            rddata_o = gpio_rdata_i;
        end else if (tmr_hit) begin
            rddata_o = tmr_rdata_i;
        end
    end

endmodule

//--- hw/gpio_regs.sv
module gpio_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  soc_bus_pkg::target_req_t req_i,
    output soc_bus_pkg::word_t       rdata_o,
    input  soc_bus_pkg::word_t       gpio_i,
    output soc_bus_pkg::word_t       gpio_o
);

    soc_bus_pkg::word_t out_q;
    soc_bus_pkg::word_t sync_q;
    soc_bus_pkg::word_t in_q;
    logic               wr_out;

    assign wr_out = req_i.write && (req_i.offset == soc_bus_pkg::GPIO_OUT_OFS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q  <= '0;
            sync_q <= '0;
            in_q   <= '0;
        end else begin
            sync_q <= gpio_i;   // first stage, may go metastable
            in_q   <= sync_q;
            if (wr_out) begin
                out_q <= soc_bus_pkg::merge_be(out_q, req_i.wrdata, req_i.be);
            end
        end
    end

    assign gpio_o = out_q;

    always_comb begin
        rdata_o = '0;
        if (req_i.read) begin
            case (req_i.offset)
                soc_bus_pkg::GPIO_OUT_OFS: rdata_o = out_q;
                soc_bus_pkg::GPIO_IN_OFS:  rdata_o = in_q;
                default:                   rdata_o = '0;
            endcase
        end
    end

endmodule

//--- hw/scratch_ram.sv
module scratch_ram (
    input  logic                     clk,
    input  logic                     rst_n,
    input  soc_bus_pkg::target_req_t req_i,
    output soc_bus_pkg::word_t       rdata_o,
    output logic                     stall_o
);

    soc_bus_pkg::word_t              mem [soc_bus_pkg::RAM_WORDS];
    soc_bus_pkg::ram_state_e         state;
    soc_bus_pkg::ram_state_e         state_nxt;
    logic [soc_bus_pkg::RAM_IDX_W-1:0] idx_q;
    logic                            access;

    assign access = req_i.read | req_i.write;

    always_comb begin
        state_nxt = state;
        case (state)
            soc_bus_pkg::RAM_IDLE: begin
                if (access) begin
                    state_nxt = soc_bus_pkg::RAM_DONE;
                end
            end
            soc_bus_pkg::RAM_DONE: begin
                state_nxt = soc_bus_pkg::RAM_IDLE;
            end
            default: begin
                state_nxt = soc_bus_pkg::RAM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= soc_bus_pkg::RAM_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // one wait cycle while the index is captured
    assign stall_o = (state == soc_bus_pkg::RAM_IDLE) && access;

    always_ff @(posedge clk) begin
        if (state == soc_bus_pkg::RAM_IDLE) begin
            idx_q <= req_i.offset[soc_bus_pkg::RAM_IDX_W+1:2];   // word index
        end
        if (state == soc_bus_pkg::RAM_DONE && req_i.write) begin
            mem[idx_q] <= soc_bus_pkg::merge_be(mem[idx_q], req_i.wrdata, req_i.be);
        end
    end

    always_comb begin
        rdata_o = '0;
        if (state == soc_bus_pkg::RAM_DONE && req_i.read) begin
            rdata_o = mem[idx_q];
        end
    end

endmodule

//--- hw/soc_bus_pkg.sv
package soc_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;
    typedef logic [11:0] offset_t;   // byte offset inside a target window

    typedef struct packed {
        addr_t addr;
        word_t wrdata;
        be_t   be;
        logic  read;
        logic  write;
    } bus_req_t;

    typedef struct packed {
        offset_t offset;
        word_t   wrdata;
        be_t     be;
        logic    read;
        logic    write;
    } target_req_t;

    typedef enum logic {
        RAM_IDLE,
        RAM_DONE
    } ram_state_e;

    // address map
    localparam addr_t RAM_BASE      = 32'h0000_0000;
    localparam addr_t GPIO_BASE     = 32'h1000_0000;
    localparam addr_t TIMER_BASE    = 32'h1000_0100;
    localparam int    RAM_WORDS     = 1024;
    localparam int    RAM_IDX_W     = $clog2(RAM_WORDS);
    localparam addr_t RAM_WINDOW    = addr_t'(RAM_WORDS * 4);
    localparam addr_t PERIPH_WINDOW = 32'h0000_0100;

    localparam offset_t GPIO_OUT_OFS    = 12'h000;
    localparam offset_t GPIO_IN_OFS     = 12'h004;
    localparam offset_t TMR_COUNT_OFS   = 12'h000;
    localparam offset_t TMR_COMPARE_OFS = 12'h004;
    localparam offset_t TMR_CTRL_OFS    = 12'h008;

    localparam int TMR_EN_BIT   = 0;
    localparam int TMR_PEND_BIT = 1;

    // replace only the enabled byte lanes of cur
    function automatic word_t merge_be(input word_t cur, input word_t wr, input be_t be);
        word_t res;
        res = cur;
        for (int b = 0; b < $bits(be_t); b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wr[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

//--- hw/soc_bus_top.sv
module soc_bus_top (
    input  logic                  clk,
    input  logic                  rst_n,

    input  soc_bus_pkg::bus_req_t req_i,
    output soc_bus_pkg::word_t    rddata_o,
    output logic                  stall_o,

    input  soc_bus_pkg::word_t    gpio_i,
    output soc_bus_pkg::word_t    gpio_o,

    input  logic                  tick_i,
    output logic                  irq_o
);

    soc_bus_pkg::target_req_t ram_req;
    soc_bus_pkg::target_req_t gpio_req;
    soc_bus_pkg::target_req_t tmr_req;
    soc_bus_pkg::word_t       ram_rdata;
    soc_bus_pkg::word_t       gpio_rdata;
    soc_bus_pkg::word_t       tmr_rdata;
    logic                     ram_stall;

    dbus_decode i_decode (
        .req_i        (req_i),
        .ram_req_o    (ram_req),
        .gpio_req_o   (gpio_req),
        .tmr_req_o    (tmr_req),
        .ram_rdata_i  (ram_rdata),
        .gpio_rdata_i (gpio_rdata),
        .tmr_rdata_i  (tmr_rdata),
        .ram_stall_i  (ram_stall),
        .rddata_o     (rddata_o),
        .stall_o      (stall_o)
    );

    scratch_ram i_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (ram_req),
        .rdata_o (ram_rdata),
        .stall_o (ram_stall)
    );

    gpio_regs i_gpio (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (gpio_req),
        .rdata_o (gpio_rdata),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o)
    );

    tick_timer i_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (tmr_req),
        .rdata_o (tmr_rdata),
        .tick_i  (tick_i),
        .irq_o   (irq_o)
    );

endmodule

//--- hw/tick_timer.sv
module tick_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  soc_bus_pkg::target_req_t req_i,
    output soc_bus_pkg::word_t       rdata_o,
    input  logic                     tick_i,
    output logic                     irq_o
);

    soc_bus_pkg::word_t count_q;
    soc_bus_pkg::word_t compare_q;
    soc_bus_pkg::word_t count_inc;
    soc_bus_pkg::word_t ctrl_word;
    logic               en_q;
    logic               pend_q;
    logic               wr_count;
    logic               wr_compare;
    logic               wr_ctrl;
    logic               tick_fire;

    assign wr_count   = req_i.write && (req_i.offset == soc_bus_pkg::TMR_COUNT_OFS);
    assign wr_compare = req_i.write && (req_i.offset == soc_bus_pkg::TMR_COMPARE_OFS);
    assign wr_ctrl    = req_i.write && (req_i.offset == soc_bus_pkg::TMR_CTRL_OFS);

    assign count_inc = count_q + 32'd1;
    assign tick_fire = tick_i && en_q && !wr_count;   // bus write wins over tick

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q   <= '0;
            compare_q <= '0;
            en_q      <= 1'b0;
            pend_q    <= 1'b0;
        end else begin
            if (wr_count) begin
                count_q <= soc_bus_pkg::merge_be(count_q, req_i.wrdata, req_i.be);
            end else if (tick_fire) begin
                count_q <= count_inc;
            end

            if (wr_compare) begin
                compare_q <= soc_bus_pkg::merge_be(compare_q, req_i.wrdata, req_i.be);
            end

            if (wr_ctrl) begin
                en_q <= req_i.wrdata[soc_bus_pkg::TMR_EN_BIT];
            end

            // a new match beats a clear in the same cycle
            if (tick_fire && (count_inc == compare_q)) begin
                pend_q <= 1'b1;
            end else if (wr_ctrl && req_i.wrdata[soc_bus_pkg::TMR_PEND_BIT]) begin
                pend_q <= 1'b0;   // write one to clear
            end
        end
    end

    assign irq_o = pend_q;

    always_comb begin
        ctrl_word                           = '0;
        ctrl_word[soc_bus_pkg::TMR_EN_BIT]   = en_q;
        ctrl_word[soc_bus_pkg::TMR_PEND_BIT] = pend_q;
    end

    always_comb begin
        rdata_o = '0;
        if (req_i.read) begin
            case (req_i.offset)
                soc_bus_pkg::TMR_COUNT_OFS:   rdata_o = count_q;
                soc_bus_pkg::TMR_COMPARE_OFS: rdata_o = compare_q;
                soc_bus_pkg::TMR_CTRL_OFS:    rdata_o = ctrl_word;
                default:                      rdata_o = '0;
            endcase
        end
    end

endmodule

//--- list.f
hw/soc_bus_pkg.sv
hw/dbus_decode.sv
hw/scratch_ram.sv
hw/gpio_regs.sv
hw/tick_timer.sv
hw/soc_bus_top.sv
tests/tb_soc_bus.sv

//--- tests/tb_soc_bus.sv
module tb_soc_bus;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  rst_n;
    soc_bus_pkg::bus_req_t req;
    soc_bus_pkg::word_t    rddata;
    logic                  stall;
    soc_bus_pkg::word_t    gpio_in;
    soc_bus_pkg::word_t    gpio_out;
    logic                  tick;
    logic                  irq;

    soc_bus_pkg::word_t    ram_model [soc_bus_pkg::RAM_WORDS];
    soc_bus_pkg::word_t    gpio_exp;
    soc_bus_pkg::word_t    count_exp;
    soc_bus_pkg::word_t    rd;
    integer                seed;
    int                    st;
    int                    pass_cnt;
    int                    fail_cnt;

    soc_bus_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (req),
        .rddata_o (rddata),
        .stall_o  (stall),
        .gpio_i   (gpio_in),
        .gpio_o   (gpio_out),
        .tick_i   (tick),
        .irq_o    (irq)
    );

    always #2 clk = ~clk;

    function automatic soc_bus_pkg::word_t lane_merge(input soc_bus_pkg::word_t old_w,
                                                      input soc_bus_pkg::word_t new_w,
                                                      input soc_bus_pkg::be_t   be);
        soc_bus_pkg::word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic soc_bus_pkg::addr_t ram_addr(input logic [9:0] w);
        return soc_bus_pkg::RAM_BASE + {20'd0, w, 2'b00};
    endfunction

    function automatic soc_bus_pkg::addr_t periph_addr(input soc_bus_pkg::addr_t   base,
                                                       input soc_bus_pkg::offset_t ofs);
        return base + {20'd0, ofs};
    endfunction

    task automatic check(input soc_bus_pkg::word_t actual, input soc_bus_pkg::word_t expected,
                         input string msg);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, expected %h, got %h", $time, msg, expected, actual);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // sample mid-cycle, count wait cycles, leave 0.5 ns past the completing edge
    task automatic complete_access(output int stalls, output soc_bus_pkg::word_t data);
        stalls = 0;
        @(negedge clk);
        while (stall) begin
            stalls++;
            @(negedge clk);
        end
        data = rddata;
        @(posedge clk);
        #0.5;
        req = '0;
    endtask

    task automatic bus_write(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::word_t data,
                             input soc_bus_pkg::be_t be, output int stalls);
        soc_bus_pkg::word_t unused;
        req.addr   = addr;
        req.wrdata = data;
        req.be     = be;
        req.read   = 1'b0;
        req.write  = 1'b1;
        complete_access(stalls, unused);
    endtask

    task automatic bus_read(input soc_bus_pkg::addr_t addr, output soc_bus_pkg::word_t data,
                            output int stalls);
        req.addr   = addr;
        req.wrdata = '0;
        req.be     = 4'hf;
        req.read   = 1'b1;
        req.write  = 1'b0;
        complete_access(stalls, data);
    endtask

    task automatic ram_write(input logic [9:0] w, input soc_bus_pkg::word_t d,
                             input soc_bus_pkg::be_t be);
        bus_write(ram_addr(w), d, be, st);
        ram_model[w] = lane_merge(ram_model[w], d, be);
    endtask

    task automatic ram_check(input logic [9:0] w, input string msg);
        bus_read(ram_addr(w), rd, st);
        check(rd, ram_model[w], msg);
    endtask

    task automatic pulse_tick();
        tick = 1'b1;
        @(posedge clk);
        #0.5;
        tick = 1'b0;
        @(posedge clk);
        #0.5;
    endtask

    task automatic report_test(input string name, input int fails_at_start);
        $display("test %s finished with %0d failed checks", name, fail_cnt - fails_at_start);
    endtask

    task automatic test_ram_byte_enables();
        int                 f0;
        logic [9:0]         w;
        soc_bus_pkg::word_t d;
        f0 = fail_cnt;
        for (int i = 0; i < 9; i++) begin
            w = 10'(100 + i);
            d = $random(seed);
            ram_write(w, d, 4'hf);
        end
        for (int i = 0; i < 9; i++) begin
            w = 10'(100 + i);
            d = $random(seed);
            ram_write(w, d, 4'(i));   // enables 0 through 8
        end
        for (int i = 0; i < 9; i++) begin
            w = 10'(100 + i);
            ram_check(w, $sformatf("ram word %0d after byte writes", w));
        end
        report_test("ram_byte_enables", f0);
    endtask

    task automatic test_ram_wait_state();
        int f0;
        f0 = fail_cnt;
        ram_write(10'd100, 32'h0bad_cafe, 4'hf);
        check(st, 1, "stall cycles of ram write");
        ram_check(10'd100, "ram read back in wait state test");
        check(st, 1, "stall cycles of ram read");
        bus_read(periph_addr(soc_bus_pkg::GPIO_BASE, soc_bus_pkg::GPIO_OUT_OFS), rd, st);
        check(st, 0, "stall cycles of gpio read");
        check(rd, gpio_exp, "gpio out after reset");
        bus_read(periph_addr(soc_bus_pkg::TIMER_BASE, soc_bus_pkg::TMR_COUNT_OFS), rd, st);
        check(st, 0, "stall cycles of timer read");
        check(rd, count_exp, "timer count after reset");
        bus_write(32'h2000_0000, 32'h0000_0001, 4'hf, st);
        check(st, 0, "stall cycles of unmapped write");
        report_test("ram_wait_state", f0);
    endtask

    task automatic test_gpio();
        int                 f0;
        soc_bus_pkg::addr_t out_a;
        soc_bus_pkg::addr_t in_a;
        soc_bus_pkg::word_t d;
        f0 = fail_cnt;
        out_a = periph_addr(soc_bus_pkg::GPIO_BASE, soc_bus_pkg::GPIO_OUT_OFS);
        in_a  = periph_addr(soc_bus_pkg::GPIO_BASE, soc_bus_pkg::GPIO_IN_OFS);
        bus_write(out_a, 32'ha5a5_5a5a, 4'hf, st);
        gpio_exp = lane_merge(gpio_exp, 32'ha5a5_5a5a, 4'hf);
        check(gpio_out, gpio_exp, "gpio_o after full write");
        bus_write(out_a, 32'h1234_5678, 4'b0101, st);
        gpio_exp = lane_merge(gpio_exp, 32'h1234_5678, 4'b0101);
        check(gpio_out, gpio_exp, "gpio_o after partial write");
        bus_read(out_a, rd, st);
        check(rd, gpio_exp, "gpio out read back");
        d       = $random(seed);
        gpio_in = d;
        repeat (3) @(posedge clk);
        #0.5;
        bus_read(in_a, rd, st);
        check(rd, d, "gpio in after sync delay");
        bus_write(in_a, ~d, 4'hf, st);   // read-only register
        check(gpio_out, gpio_exp, "gpio_o after write to input register");
        bus_read(in_a, rd, st);
        check(rd, d, "gpio in after write attempt");
        report_test("gpio", f0);
    endtask

    task automatic test_timer();
        int                 f0;
        soc_bus_pkg::addr_t cnt_a;
        soc_bus_pkg::addr_t ctrl_a;
        soc_bus_pkg::word_t en_val;
        soc_bus_pkg::word_t pend_val;
        f0 = fail_cnt;
        cnt_a    = periph_addr(soc_bus_pkg::TIMER_BASE, soc_bus_pkg::TMR_COUNT_OFS);
        ctrl_a   = periph_addr(soc_bus_pkg::TIMER_BASE, soc_bus_pkg::TMR_CTRL_OFS);
        en_val   = 32'd1 << soc_bus_pkg::TMR_EN_BIT;
        pend_val = 32'd1 << soc_bus_pkg::TMR_PEND_BIT;
        check({31'd0, irq}, 32'd0, "irq before timer setup");
        bus_write(periph_addr(soc_bus_pkg::TIMER_BASE, soc_bus_pkg::TMR_COMPARE_OFS),
                  32'd5, 4'hf, st);
        bus_write(ctrl_a, en_val, 4'hf, st);
        repeat (5) begin
            pulse_tick();
            count_exp++;
        end
        bus_read(cnt_a, rd, st);
        check(rd, count_exp, "count after five ticks");
        check({31'd0, irq}, 32'd1, "irq on compare match");
        bus_read(ctrl_a, rd, st);
        check(rd, en_val | pend_val, "control with pending set");
        bus_write(ctrl_a, en_val | pend_val, 4'hf, st);   // clear pending
        check({31'd0, irq}, 32'd0, "irq after pending clear");
        bus_read(ctrl_a, rd, st);
        check(rd, en_val, "control after pending clear");
        bus_write(ctrl_a, 32'd0, 4'hf, st);
        repeat (3) pulse_tick();
        bus_read(cnt_a, rd, st);
        check(rd, count_exp, "count with timer disabled");
        // write and tick on the same edge
        bus_write(ctrl_a, en_val, 4'hf, st);
        tick = 1'b1;
        bus_write(cnt_a, 32'h0000_0100, 4'hf, st);
        tick      = 1'b0;
        count_exp = 32'h0000_0100;
        bus_read(cnt_a, rd, st);
        check(rd, count_exp, "count write against tick");
        bus_write(ctrl_a, 32'd0, 4'hf, st);
        report_test("timer", f0);
    endtask

    task automatic test_unmapped();
        int f0;
        f0 = fail_cnt;
        ram_write(10'd0, 32'h7e57_0000, 4'hf);
        bus_read(32'h2000_0000, rd, st);
        check(rd, 32'd0, "read at 0x2000_0000");
        bus_write(32'h2000_0000, 32'hdead_beef, 4'hf, st);
        bus_read(32'h0000_1000, rd, st);
        check(rd, 32'd0, "read just past ram");
        bus_write(32'h0000_1000, 32'hffff_ffff, 4'hf, st);
        ram_check(10'd0, "ram word 0 after unmapped writes");
        bus_read(periph_addr(soc_bus_pkg::GPIO_BASE, 12'h008), rd, st);
        check(rd, 32'd0, "gpio unlisted offset");
        bus_write(periph_addr(soc_bus_pkg::GPIO_BASE, 12'h008), 32'hffff_ffff, 4'hf, st);
        check(gpio_out, gpio_exp, "gpio_o after unlisted write");
        bus_read(periph_addr(soc_bus_pkg::TIMER_BASE, 12'h00c), rd, st);
        check(rd, 32'd0, "timer unlisted offset");
        bus_write(periph_addr(soc_bus_pkg::TIMER_BASE, 12'h00c), 32'h0000_0042, 4'hf, st);
        bus_write(32'h1000_0200, 32'h0000_0000, 4'hf, st);
        bus_read(periph_addr(soc_bus_pkg::TIMER_BASE, soc_bus_pkg::TMR_COUNT_OFS), rd, st);
        check(rd, count_exp, "timer count after unlisted writes");
        bus_read(periph_addr(soc_bus_pkg::TIMER_BASE, soc_bus_pkg::TMR_COMPARE_OFS), rd, st);
        check(rd, 32'd5, "timer compare after unlisted writes");   // set by the timer test
        report_test("unmapped", f0);
    endtask

    task automatic test_random_ram();
        int                 f0;
        logic [9:0]         w;
        soc_bus_pkg::addr_t a;
        soc_bus_pkg::word_t r;
        soc_bus_pkg::word_t d;
        f0 = fail_cnt;
        for (int i = 0; i < 64; i++) begin
            w = 10'(i);
            a = ram_addr(w);
            ram_write(w, a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9, 4'hf);
        end
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            w = {4'd0, r[5:0]};
            if (r[16]) begin
                d = $random(seed);
                ram_write(w, d, r[11:8]);
            end else begin
                ram_check(w, $sformatf("random read %0d of word %0d", i, w));
            end
            check(st, 1, "stall cycles of random access");
        end
        report_test("random_ram", f0);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = '0;
        gpio_in   = '0;
        tick      = 1'b0;
        seed      = 32;
        pass_cnt  = 0;
        fail_cnt  = 0;
        gpio_exp  = '0;
        count_exp = '0;
        repeat (8) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        check({31'd0, stall}, 32'd0, "stall after reset");
        check({31'd0, irq}, 32'd0, "irq after reset");
        check(gpio_out, 32'd0, "gpio_o after reset");

        test_ram_byte_enables();
        test_ram_wait_state();
        test_gpio();
        test_timer();
        test_unmapped();
        test_random_ram();

        $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (4000) @(posedge clk);   // tests need well under 1000 cycles
        $display("run timed out: tests did not finish within 4000 clock cycles");
        $display("Simulation failed");
        $finish;
    end

endmodule
